// File: verilog/asteroidPkg.sv
package asteroidPkg;

    localparam int ASTEROID_COUNT = 8;
    localparam int COORD_WIDTH = 11;
    localparam int SCREEN_WIDTH = 640;
    localparam int SCREEN_HEIGHT = 480;
    localparam int SPRITE_SIZE = 32;
    localparam int DEACTIVATE_FRAMES = 10;
    localparam logic [7:0] COLOR_NORMAL = 8'hB6;
    localparam logic [7:0] COLOR_HIT = 8'hE0;
    localparam string SHAPE_FILE = "verilog/asteroidShape.hex";

    // Largest top-left coordinate that keeps the sprite fully on screen.
    localparam logic signed [COORD_WIDTH-1:0] POS_MAX_X = COORD_WIDTH'(SCREEN_WIDTH - SPRITE_SIZE);
    localparam logic signed [COORD_WIDTH-1:0] POS_MAX_Y = COORD_WIDTH'(SCREEN_HEIGHT - SPRITE_SIZE);

    typedef struct packed {
        logic signed [COORD_WIDTH-1:0] x;
        logic signed [COORD_WIDTH-1:0] y;
    } pixelPosT;

    typedef logic [7:0] rgbT;

    typedef struct packed {
        logic     covered; // Pixel inside the rectangle of a live asteroid.
        pixelPosT offset;
        logic     hit;
        logic     live;
    } spriteHitT;

    typedef logic [$clog2(ASTEROID_COUNT)-1:0] asteroidIndexT;

    // Two rows of four.
    function automatic pixelPosT initialPos(input int index);
        pixelPosT pos;
        pos.x = COORD_WIDTH'(40 + 140 * (index % 4));
        pos.y = COORD_WIDTH'(30 + 100 * (index / 4));
        return pos;
    endfunction

    function automatic pixelPosT initialSpeed(input int index);
        pixelPosT speed;
        speed.x = COORD_WIDTH'(2 + (index % 3));
        speed.y = COORD_WIDTH'(1 + (index % 2));
        return speed;
    endfunction

endpackage

// File: verilog/collisionRouter.sv
`timescale 1ns/10ps

module collisionRouter (
    input  logic                                    clk,
    input  logic                                    resetN,
    input  logic                                    enable,
    input  logic                                    startOfFrame,
    input  logic                                    shotHit,
    input  asteroidPkg::asteroidIndexT              chosenIndex,
    input  logic                                    chosenValid,
    output logic                                    frameTick,
    output logic [asteroidPkg::ASTEROID_COUNT-1:0] hitStrobe
);
    import asteroidPkg::*;

    asteroidIndexT indexD;
    logic          validD;

    assign frameTick = startOfFrame & enable; // Shared by every unit.

    // The selection is one cycle ahead of the bitmap register, so delay it once.
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            indexD <= '0;
            validD <= 1'b0;
        end else begin
            indexD <= chosenIndex;
            validD <= chosenValid;
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            hitStrobe <= '0;
        end else begin
            hitStrobe <= '0;
            if (shotHit && validD) begin
                hitStrobe[indexD] <= 1'b1; // Only the asteroid now on the output.
            end
        end
    end

endmodule

// File: verilog/asteroidUnit.sv
`timescale 1ns/10ps

module asteroidUnit #(
    parameter int index = 0
) (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   frameTick,
    input  logic                   hitStrobe,
    input  asteroidPkg::pixelPosT  pixel,
    output asteroidPkg::spriteHitT sprite
);
    import asteroidPkg::*;

    localparam pixelPosT START = initialPos(index);
    localparam pixelPosT SPEED = initialSpeed(index);

    pixelPosT                          pos;
    logic                              dirX;      // High while moving towards smaller x.
    logic                              dirY;
    logic                              hit;
    logic                              live;
    logic [$clog2(DEACTIVATE_FRAMES)-1:0] frameCount;
    logic signed [COORD_WIDTH-1:0]     stepX;
    logic signed [COORD_WIDTH-1:0]     stepY;
    logic signed [COORD_WIDTH-1:0]     nextX;
    logic signed [COORD_WIDTH-1:0]     nextY;
    logic                              bounceX;
    logic                              bounceY;
    logic signed [COORD_WIDTH-1:0]     offX;
    logic signed [COORD_WIDTH-1:0]     offY;
    logic                              inRect;

    // Mirror a step that left the range 0..limit back into it.
    function automatic logic signed [COORD_WIDTH-1:0] reflect(
        input logic signed [COORD_WIDTH-1:0] step,
        input logic signed [COORD_WIDTH-1:0] limit
    );
        if (step < 0) begin
            return -step;
        end else if (step > limit) begin
            return limit - (step - limit);
        end
        return step;
    endfunction

    always_comb begin
        stepX   = dirX ? pos.x - SPEED.x : pos.x + SPEED.x;
        stepY   = dirY ? pos.y - SPEED.y : pos.y + SPEED.y;
        bounceX = (stepX < 0) || (stepX > POS_MAX_X);
        bounceY = (stepY < 0) || (stepY > POS_MAX_Y);
        nextX   = reflect(stepX, POS_MAX_X);
        nextY   = reflect(stepY, POS_MAX_Y);
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            pos        <= START;
            dirX       <= 1'b0;
            dirY       <= 1'b0;
            hit        <= 1'b0;
            live       <= 1'b1;
            frameCount <= '0;
        end else begin
            if (hitStrobe && live) begin
                hit <= 1'b1;
            end
            if (frameTick && !hit) begin
                pos.x <= nextX;
                pos.y <= nextY;
                dirX  <= dirX ^ bounceX;
                dirY  <= dirY ^ bounceY;
            end
            // Count frames from the hit until the asteroid vanishes.
            if (frameTick && hit && live) begin
                if (frameCount == $bits(frameCount)'(DEACTIVATE_FRAMES - 1)) begin
                    live <= 1'b0;
                end
                frameCount <= frameCount + 1'b1;
            end
        end
    end

    always_comb begin
        offX   = pixel.x - pos.x;
        offY   = pixel.y - pos.y;
        inRect = (offX >= 0) && (offX < SPRITE_SIZE) && (offY >= 0) && (offY < SPRITE_SIZE);
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            sprite <= '{covered: 1'b0, offset: '0, hit: 1'b0, live: 1'b1};
        end else begin
            sprite.covered  <= inRect && live;
            sprite.offset.x <= offX;
            sprite.offset.y <= offY;
            sprite.hit      <= hit;
            sprite.live     <= live;
        end
    end

endmodule

// File: verilog/asteroidPriority.sv
`timescale 1ns/10ps

module asteroidPriority (
    input  logic                       clk,
    input  logic                       resetN,
    input  asteroidPkg::spriteHitT     sprites [asteroidPkg::ASTEROID_COUNT],
    output asteroidPkg::pixelPosT      chosenOffset,
    output logic                       chosenCover,
    output logic                       chosenHit,
    output asteroidPkg::asteroidIndexT chosenIndex,
    output logic                       chosenValid,
    output logic                       explodedPulse,
    output logic                       allDestroyed
);
    import asteroidPkg::*;

    logic [ASTEROID_COUNT-1:0] hitVec;
    logic [ASTEROID_COUNT-1:0] liveVec;
    logic [ASTEROID_COUNT-1:0] prevHit;

    // Scanning downwards leaves the lowest covering index as the winner.
    always_comb begin
        chosenCover  = 1'b0;
        chosenOffset = '0;
        chosenHit    = 1'b0;
        chosenIndex  = '0;
        for (int i = ASTEROID_COUNT - 1; i >= 0; i--) begin
            hitVec[i]  = sprites[i].hit;
            liveVec[i] = sprites[i].live;
            if (sprites[i].covered && sprites[i].live) begin
                chosenCover  = 1'b1;
                chosenOffset = sprites[i].offset;
                chosenHit    = sprites[i].hit;
                chosenIndex  = asteroidIndexT'(i);
            end
        end
    end

    assign chosenValid = chosenCover;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            prevHit <= '0;
        end else begin
            prevHit <= hitVec;
        end
    end

    assign explodedPulse = |(hitVec & ~prevHit); // One cycle per rising hit flag.
    assign allDestroyed  = ~|liveVec;

endmodule

// File: verilog/asteroidBitmap.sv
`timescale 1ns/10ps

module asteroidBitmap (
    input  logic                  clk,
    input  logic                  resetN,
    input  asteroidPkg::pixelPosT offset,
    input  logic                  covered,
    input  logic                  hit,
    output logic                  drawRequest,
    output asteroidPkg::rgbT      rgb
);
    import asteroidPkg::*;

    logic [SPRITE_SIZE-1:0]         shapeRom [SPRITE_SIZE];
    logic [$clog2(SPRITE_SIZE)-1:0] rowSel;
    logic [$clog2(SPRITE_SIZE)-1:0] colSel;
    logic                           maskBit;
    logic                           draw;

    initial begin
        $readmemh(SHAPE_FILE, shapeRom);
    end

    always_comb begin
        rowSel  = offset.y[$clog2(SPRITE_SIZE)-1:0];
        colSel  = ~offset.x[$clog2(SPRITE_SIZE)-1:0]; // MSB holds column zero.
        maskBit = shapeRom[rowSel][colSel];
        draw    = covered && maskBit;
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            drawRequest <= 1'b0;
            rgb         <= '0;
        end else begin
            drawRequest <= draw;
            if (!draw) begin
                rgb <= '0;
            end else if (hit) begin
                rgb <= COLOR_HIT;
            end else begin
                rgb <= COLOR_NORMAL;
            end
        end
    end

endmodule

// File: verilog/asteroidField.sv
`timescale 1ns/10ps

module asteroidField (
    input  logic                 clk,
    input  logic                 resetN,
    input  logic                 enable,
    input  logic                 startOfFrame,
    input  asteroidPkg::pixelPosT pixel,
    input  logic                 shotHit,
    output logic                 asteroidsDr,
    output asteroidPkg::rgbT     asteroidsRgb,
    output logic                 explodedPulse,
    output logic                 allDestroyed
);
    import asteroidPkg::*;

    logic                      frameTick;
    logic [ASTEROID_COUNT-1:0] hitStrobe;
    spriteHitT                 sprites [ASTEROID_COUNT];
    pixelPosT                  chosenOffset;
    logic                      chosenCover;
    logic                      chosenHit;
    asteroidIndexT             chosenIndex;
    logic                      chosenValid;

    collisionRouter router (
        .clk         (clk),
        .resetN      (resetN),
        .enable      (enable),
        .startOfFrame(startOfFrame),
        .shotHit     (shotHit),
        .chosenIndex (chosenIndex),
        .chosenValid (chosenValid),
        .frameTick   (frameTick),
        .hitStrobe   (hitStrobe)
    );

    for (genvar i = 0; i < ASTEROID_COUNT; i++) begin : genUnits
        asteroidUnit #(.index(i)) unit (
            .clk      (clk),
            .resetN   (resetN),
            .frameTick(frameTick),
            .hitStrobe(hitStrobe[i]),
            .pixel    (pixel),
            .sprite   (sprites[i])
        );
    end

    asteroidPriority selector (
        .clk          (clk),
        .resetN       (resetN),
        .sprites      (sprites),
        .chosenOffset (chosenOffset),
        .chosenCover  (chosenCover),
        .chosenHit    (chosenHit),
        .chosenIndex  (chosenIndex),
        .chosenValid  (chosenValid),
        .explodedPulse(explodedPulse),
        .allDestroyed (allDestroyed)
    );

    asteroidBitmap bitmap (
        .clk        (clk),
        .resetN     (resetN),
        .offset     (chosenOffset),
        .covered    (chosenCover),
        .hit        (chosenHit),
        .drawRequest(asteroidsDr),
        .rgb        (asteroidsRgb)
    );

endmodule

// File: verif/asteroidFieldTb.sv
`timescale 1ns/10ps

module asteroidFieldTb;
    import asteroidPkg::*;

    localparam int MOTION_FRAMES = 200;
    localparam int PRIORITY_FRAMES = 150;
    localparam int SHOT_FRAMES = 20;   // Frames spent looking for a visible target.
    // Every asteroid may be shot once, plus the frames that let the hits deactivate.
    localparam int TOTAL_FRAMES = MOTION_FRAMES + PRIORITY_FRAMES +
                                  ASTEROID_COUNT * (SHOT_FRAMES + 1) + 2 * DEACTIVATE_FRAMES + 4;
    localparam int PROBES = 64;
    localparam int IDLE_X = 700;       // Off screen, never covered.
    localparam int IDLE_Y = 500;

    logic        clk = 1'b0;
    logic        resetN;
    logic        enable;
    logic        startOfFrame;
    pixelPosT    pixel;
    logic        shotHit;
    logic        asteroidsDr;
    rgbT         asteroidsRgb;
    logic        explodedPulse;
    logic        allDestroyed;

    logic [31:0]               seed = 32'h414a_cb5b;
    logic [SPRITE_SIZE-1:0]    mask [SPRITE_SIZE];
    int                        posX [ASTEROID_COUNT];
    int                        posY [ASTEROID_COUNT];
    int                        velX [ASTEROID_COUNT];
    int                        velY [ASTEROID_COUNT];
    int                        frameCnt [ASTEROID_COUNT];
    logic [ASTEROID_COUNT-1:0] hitSt;
    logic [ASTEROID_COUNT-1:0] liveSt;
    logic [ASTEROID_COUNT-1:0] hitOld;
    logic [ASTEROID_COUNT-1:0] strobeNow;
    logic [ASTEROID_COUNT-1:0] strobeNext;
    logic                      prevTick;
    logic                      expDr [2];   // Index 0 is due on the output this cycle.
    rgbT                       expRgb [2];
    logic                      expValid [2];
    int                        expIdx [2];
    int                        checks = 0;
    int                        errors = 0;
    int                        pulses = 0;

    asteroidField dut (.*);

    always #50 clk = ~clk;

    function automatic int randBelow(input int n);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return int'(seed[30:8] % n);
    endfunction

    task automatic checkDraw(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkRgb(input string name, input rgbT got, input rgbT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic resetModel();
        for (int i = 0; i < ASTEROID_COUNT; i++) begin
            posX[i] = 40 + 140 * (i % 4);
            posY[i] = 30 + 100 * (i / 4);
            velX[i] = 2 + i % 3;
            velY[i] = 1 + i % 2;
            frameCnt[i] = 0;
        end
        hitSt = '0;
        liveSt = '1;
        hitOld = '0;
        strobeNow = '0;
        strobeNext = '0;
        prevTick = 1'b0;
        for (int s = 0; s < 2; s++) begin
            expDr[s] = 1'b0;
            expRgb[s] = '0;
            expValid[s] = 1'b0;
            expIdx[s] = 0;
        end
    endtask

    // A step past either edge is mirrored back and the direction flips.
    task automatic moveAxis(inout int pos, inout int vel, input int limit);
        pos = pos + vel;
        if (pos < 0 || pos > limit) begin
            pos = (pos < 0) ? -pos : 2 * limit - pos;
            vel = -vel;
        end
    endtask

    task automatic advanceModel();
        logic newHit;
        for (int i = 0; i < ASTEROID_COUNT; i++) begin
            newHit = hitSt[i] | (strobeNow[i] & liveSt[i]);
            if (prevTick && !hitSt[i]) begin
                moveAxis(posX[i], velX[i], SCREEN_WIDTH - SPRITE_SIZE);
                moveAxis(posY[i], velY[i], SCREEN_HEIGHT - SPRITE_SIZE);
            end
            if (prevTick && hitSt[i] && liveSt[i]) begin
                frameCnt[i]++;
                if (frameCnt[i] == DEACTIVATE_FRAMES) liveSt[i] = 1'b0;
            end
            hitSt[i] = newHit;
        end
    endtask

    function automatic int coverIndex(input int px, input int py);
        for (int i = 0; i < ASTEROID_COUNT; i++) begin
            if (liveSt[i] && px >= posX[i] && px < posX[i] + SPRITE_SIZE &&
                py >= posY[i] && py < posY[i] + SPRITE_SIZE) return i;
        end
        return -1;
    endfunction

    // Mode -2 aims at the higher index of an overlapping pair, -1 at any asteroid.
    function automatic int pickTarget(input int mode);
        if (mode >= 0) return mode;
        if (mode == -2) begin
            for (int j = 1; j < ASTEROID_COUNT; j++) begin
                for (int i = 0; i < j; i++) begin
                    if (posX[i] - posX[j] < SPRITE_SIZE && posX[j] - posX[i] < SPRITE_SIZE &&
                        posY[i] - posY[j] < SPRITE_SIZE && posY[j] - posY[i] < SPRITE_SIZE &&
                        liveSt[i] && liveSt[j]) return j;
                end
            end
        end
        return randBelow(ASTEROID_COUNT);
    endfunction

    task automatic stepCycle(input logic sof, input logic en, input int px, input int py,
                             input logic shot);
        int   w;
        logic draw;
        logic expPulse;
        logic expDestroyed;
        @(posedge clk);
        startOfFrame <= sof;
        enable       <= en;
        pixel        <= '{x: COORD_WIDTH'(px), y: COORD_WIDTH'(py)};
        shotHit      <= shot;
        expPulse = |(hitSt & ~hitOld);   // Sprite flags lag the unit state by one cycle.
        expDestroyed = ~|liveSt;
        hitOld = hitSt;
        advanceModel();
        strobeNow = strobeNext;
        strobeNext = '0;
        if (shot && expValid[0]) strobeNext[expIdx[0]] = 1'b1;
        w = coverIndex(px, py);
        draw = 1'b0;
        if (w >= 0) draw = mask[py - posY[w]][SPRITE_SIZE - 1 - (px - posX[w])];
        prevTick = sof && en;
        @(negedge clk);
        checkDraw("asteroidsDr", asteroidsDr, expDr[0]);
        checkRgb("asteroidsRgb", asteroidsRgb, expRgb[0]);
        checkFlag("explodedPulse", explodedPulse, expPulse);
        checkFlag("allDestroyed", allDestroyed, expDestroyed);
        if (explodedPulse === 1'b1) pulses++;
        expDr[0] = expDr[1];
        expRgb[0] = expRgb[1];
        expValid[0] = expValid[1];
        expIdx[0] = expIdx[1];
        expDr[1] = draw;
        expRgb[1] = !draw ? 8'h00 : (hitSt[w] ? COLOR_HIT : COLOR_NORMAL);
        expValid[1] = (w >= 0);
        expIdx[1] = w;
    endtask

    task automatic runFrame(input logic en, input int mode);
        int t;
        int px;
        int py;
        stepCycle(1'b1, en, IDLE_X, IDLE_Y, 1'b0);
        for (int n = 0; n < PROBES; n++) begin
            if (randBelow(2) == 0) begin
                t = pickTarget(mode);
                px = posX[t] + randBelow(SPRITE_SIZE);
                py = posY[t] + randBelow(SPRITE_SIZE);
            end else begin
                px = randBelow(SCREEN_WIDTH);
                py = randBelow(SCREEN_HEIGHT);
            end
            stepCycle(1'b0, en, px, py, 1'b0);
        end
    endtask

    // Finds a pixel where asteroid k wins, shows it, and fires as it reaches the output.
    task automatic shoot(input int k);
        int   px;
        int   py;
        int   pulsesBefore;
        logic found;
        found = 1'b0;
        for (int n = 0; n < SHOT_FRAMES * PROBES && !found; n++) begin
            if (n % PROBES == PROBES - 1) runFrame(1'b1, -1);
            px = posX[k] + randBelow(SPRITE_SIZE);
            py = posY[k] + randBelow(SPRITE_SIZE);
            found = (coverIndex(px, py) == k);
        end
        if (!found) begin
            errors++;
            $display("Asteroid %0d never became the visible winner, so it was not shot", k);
            return;
        end
        pulsesBefore = pulses;
        stepCycle(1'b0, 1'b1, px, py, 1'b0);
        stepCycle(1'b0, 1'b1, IDLE_X, IDLE_Y, 1'b0);
        stepCycle(1'b0, 1'b1, IDLE_X, IDLE_Y, 1'b1);
        for (int n = 0; n < 6 && pulses == pulsesBefore; n++) begin
            stepCycle(1'b0, 1'b1, IDLE_X, IDLE_Y, 1'b0);
        end
        repeat (2) stepCycle(1'b0, 1'b1, IDLE_X, IDLE_Y, 1'b0);
        if (pulses - pulsesBefore != 1) begin
            errors++;
            $display("Shooting asteroid %0d gave %0d explosion pulses instead of one",
                     k, pulses - pulsesBefore);
        end
    endtask

    task automatic report(input string name, input int errBefore);
        if (errors == errBefore) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - errBefore);
    endtask

    initial begin
        int errBefore;
        int k;
        int j;
        int swap;
        int order [ASTEROID_COUNT];
        $readmemh("verilog/asteroidShape.hex", mask);
        resetN = 1'b0;
        enable = 1'b0;
        startOfFrame = 1'b0;
        pixel = '0;
        shotHit = 1'b0;
        resetModel();
        repeat (16) @(posedge clk);
        resetN <= 1'b1;

        errBefore = errors;
        @(negedge clk);
        checkDraw("asteroidsDr", asteroidsDr, 1'b0);
        checkFlag("explodedPulse", explodedPulse, 1'b0);
        checkFlag("allDestroyed", allDestroyed, 1'b0);
        for (int i = 0; i < ASTEROID_COUNT; i++) begin
            stepCycle(1'b0, 1'b0, posX[i] + 16, posY[i] + 16, 1'b0);
        end
        repeat (2) stepCycle(1'b0, 1'b0, IDLE_X, IDLE_Y, 1'b0);
        report("reset state", errBefore);

        errBefore = errors;
        repeat (MOTION_FRAMES) runFrame(randBelow(4) != 0, -1);
        report("motion and bounce", errBefore);

        errBefore = errors;
        repeat (PRIORITY_FRAMES) runFrame(1'b1, -2);
        report("priority", errBefore);

        // All asteroids are still unhit, so a misrouted blank shot would pulse.
        errBefore = errors;
        repeat (2) stepCycle(1'b0, 1'b1, IDLE_X, IDLE_Y, 1'b0);
        k = pulses;
        stepCycle(1'b0, 1'b1, IDLE_X, IDLE_Y, 1'b1); // Nothing is on the output here.
        repeat (6) stepCycle(1'b0, 1'b1, IDLE_X, IDLE_Y, 1'b0);
        if (pulses != k) begin
            errors++;
            $display("A shot over a blank pixel produced an explosion pulse");
        end
        k = randBelow(ASTEROID_COUNT);
        shoot(k);
        repeat (DEACTIVATE_FRAMES + 2) runFrame(1'b1, k);
        report("hit and deactivation", errBefore);

        errBefore = errors;
        for (int i = 0; i < ASTEROID_COUNT; i++) order[i] = i;
        for (int i = ASTEROID_COUNT - 1; i > 0; i--) begin
            j = randBelow(i + 1);
            swap = order[i];
            order[i] = order[j];
            order[j] = swap;
        end
        for (int i = 0; i < ASTEROID_COUNT; i++) begin
            if (liveSt[order[i]] && !hitSt[order[i]]) shoot(order[i]);
        end
        repeat (DEACTIVATE_FRAMES + 1) runFrame(1'b1, -1);
        checkFlag("allDestroyed", allDestroyed, 1'b1);
        report("clearing the field", errBefore);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(TOTAL_FRAMES * 70 * 100 * 2);
        $display("Watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: verilog/asteroidShape.hex
// One 32-bit word per sprite row, row 0 first; bit 31 is offsetX 0.
000FF000
007FFE00
01FFFF80
03FFFFC0
07FFFFE0
0FFFFFF0
1FFFFFF8
1FFFFFF8
3FFFFFFC
3FFFFFFC
7FFFFFFE
7FF87FFE
7FF03FFE
FFF03FFF
FFF87FFF
FFFFFFFF
FFFFFFFF
FFFFE1FF
FFFFC0FF
7FFFE1FE
7FFFFFFE
3FFFFFFC
3FFFFFFC
1FFFFFF8
1FFFFFF8
0FFFFFF0
07FFFFE0
03FFFFC0
01FFFF80
007FFE00
001FF800
00000000

// File: asteroidField.f
verilog/asteroidPkg.sv
verilog/collisionRouter.sv
verilog/asteroidUnit.sv
verilog/asteroidPriority.sv
verilog/asteroidBitmap.sv
verilog/asteroidField.sv
verif/asteroidFieldTb.sv

// File: Bender.yml
package:
  name: asteroidField

sources:
  - verilog/asteroidPkg.sv
  - verilog/collisionRouter.sv
  - verilog/asteroidUnit.sv
  - verilog/asteroidPriority.sv
  - verilog/asteroidBitmap.sv
  - verilog/asteroidField.sv
  - target: test
    files:
      - verif/asteroidFieldTb.sv
